/* source/ecc_dsa_pkg.sv */
// signing engine package with widths, moduli, encodings and the instruction word
package ecc_dsa_pkg;

    localparam int REG_SIZE    = 32;
    localparam int OPR_ADDR_W  = 4;
    localparam int PROG_ADDR_W = 5;

    typedef logic [REG_SIZE-1:0] operand_t;

    // toy curve stand-in, group order sits below the field prime
    localparam operand_t PRIME       = 32'd4294967291;
    localparam operand_t GROUP_ORDER = 32'd4294967279;
    localparam operand_t GEN_X       = 32'd2357111317;

    typedef enum logic [1:0] {CMD_NOP, CMD_KEYGEN, CMD_SIGN} cmd_e;

    typedef enum logic [2:0] {UOP_NOP, UOP_WR_CORE, UOP_RD_CORE, UOP_ARITH, UOP_END} uop_e;

    typedef enum logic [3:0] {
        ID_CONST_ZERO, ID_CONST_GEN, ID_PRIVKEY, ID_NONCE, ID_MSG, ID_PUBKEY, ID_R, ID_S
    } reg_id_e;

    typedef enum logic [1:0] {OP_MUL_P, OP_MUL_Q, OP_ADD_Q} arith_op_e;

    // ----------------------------------------
    // instruction word, kind field shared by both views
    // ----------------------------------------
    typedef struct packed {
        uop_e                  kind;
        reg_id_e               reg_id;
        logic [OPR_ADDR_W-1:0] mem_addr;
        logic [4:0]            rsvd;
    } instr_xfer_t;

    typedef struct packed {
        uop_e                  kind;
        arith_op_e             op;
        logic [OPR_ADDR_W-1:0] dst_a;
        logic [OPR_ADDR_W-1:0] src_b;
        logic [2:0]            rsvd;
    } instr_arith_t;

    typedef union packed {
        instr_xfer_t  xfer;
        instr_arith_t arith;
    } instr_u;

    // program entry points in the sequencer ROM
    localparam logic [PROG_ADDR_W-1:0] PROG_RESET  = 5'd0;
    localparam logic [PROG_ADDR_W-1:0] PROG_KEYGEN = 5'd5;
    localparam logic [PROG_ADDR_W-1:0] PROG_SIGN   = 5'd10;

endpackage

/* source/ecc_arith_if.sv */
// arithmetic unit bundle shared by the controller, register bank and unit
interface ecc_arith_if;
    import ecc_dsa_pkg::*;

    // request from the controller
    logic                  start;
    arith_op_e             op;
    logic [OPR_ADDR_W-1:0] dst_addr;
    logic [OPR_ADDR_W-1:0] src_a_addr;
    logic [OPR_ADDR_W-1:0] src_b_addr;
    // write port used by the register bank
    logic                  we;
    logic [OPR_ADDR_W-1:0] waddr;
    operand_t              wdata;
    // unit responses
    operand_t              rdata;
    logic                  busy;

    modport ctrl (output start, op, dst_addr, src_a_addr, src_b_addr, input busy);
    modport bank (output we, waddr, wdata, input rdata);
    modport unit (input start, op, dst_addr, src_a_addr, src_b_addr, we, waddr, wdata,
                  output rdata, busy);

endinterface

/* source/dsa_sequencer_rom.sv */
// sequencer ROM holding the reset, keygen and sign microprograms
module dsa_sequencer_rom (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize_i,
    input  logic [ecc_dsa_pkg::PROG_ADDR_W-1:0] addr_i,
    output ecc_dsa_pkg::instr_u                 instr_o
);
    import ecc_dsa_pkg::*;

    // data memory slots
    localparam logic [OPR_ADDR_W-1:0] A_GEN   = 4'd0;
    localparam logic [OPR_ADDR_W-1:0] A_PRIV  = 4'd1;
    localparam logic [OPR_ADDR_W-1:0] A_NONCE = 4'd2;
    localparam logic [OPR_ADDR_W-1:0] A_MSG   = 4'd3;

    instr_u rom_word;

    function automatic instr_u xfer_word(uop_e k, reg_id_e id, logic [OPR_ADDR_W-1:0] a);
        instr_u w;
        w.xfer = '{kind: k, reg_id: id, mem_addr: a, rsvd: '0};
        return w;
    endfunction

    function automatic instr_u arith_word(arith_op_e o, logic [OPR_ADDR_W-1:0] d,
                                         logic [OPR_ADDR_W-1:0] b);
        instr_u w;
        w.arith = '{kind: UOP_ARITH, op: o, dst_a: d, src_b: b, rsvd: '0};
        return w;
    endfunction

    always_comb begin
        case (addr_i)
            // clear the working slots
            PROG_RESET         : rom_word = xfer_word(UOP_WR_CORE, ID_CONST_ZERO, A_GEN);
            PROG_RESET + 5'd1  : rom_word = xfer_word(UOP_WR_CORE, ID_CONST_ZERO, A_PRIV);
            PROG_RESET + 5'd2  : rom_word = xfer_word(UOP_WR_CORE, ID_CONST_ZERO, A_NONCE);
            PROG_RESET + 5'd3  : rom_word = xfer_word(UOP_WR_CORE, ID_CONST_ZERO, A_MSG);
            PROG_RESET + 5'd4  : rom_word = xfer_word(UOP_END, ID_CONST_ZERO, A_GEN);
            // pubkey = privkey * G mod p
            PROG_KEYGEN        : rom_word = xfer_word(UOP_WR_CORE, ID_CONST_GEN, A_GEN);
            PROG_KEYGEN + 5'd1 : rom_word = xfer_word(UOP_WR_CORE, ID_PRIVKEY, A_PRIV);
            PROG_KEYGEN + 5'd2 : rom_word = arith_word(OP_MUL_P, A_GEN, A_PRIV);
            PROG_KEYGEN + 5'd3 : rom_word = xfer_word(UOP_RD_CORE, ID_PUBKEY, A_GEN);
            PROG_KEYGEN + 5'd4 : rom_word = xfer_word(UOP_END, ID_CONST_ZERO, A_GEN);
            // r = k * G mod p, then s = h + privkey * r mod q
            PROG_SIGN          : rom_word = xfer_word(UOP_WR_CORE, ID_CONST_GEN, A_GEN);
            PROG_SIGN + 5'd1   : rom_word = xfer_word(UOP_WR_CORE, ID_NONCE, A_NONCE);
            PROG_SIGN + 5'd2   : rom_word = arith_word(OP_MUL_P, A_NONCE, A_GEN);
            PROG_SIGN + 5'd3   : rom_word = xfer_word(UOP_RD_CORE, ID_R, A_NONCE);
            PROG_SIGN + 5'd4   : rom_word = xfer_word(UOP_WR_CORE, ID_PRIVKEY, A_PRIV);
            PROG_SIGN + 5'd5   : rom_word = arith_word(OP_MUL_Q, A_NONCE, A_PRIV);
            PROG_SIGN + 5'd6   : rom_word = xfer_word(UOP_WR_CORE, ID_MSG, A_MSG);
            PROG_SIGN + 5'd7   : rom_word = arith_word(OP_ADD_Q, A_NONCE, A_MSG);
            PROG_SIGN + 5'd8   : rom_word = xfer_word(UOP_RD_CORE, ID_S, A_NONCE);
            PROG_SIGN + 5'd9   : rom_word = xfer_word(UOP_END, ID_CONST_ZERO, A_GEN);
            default            : rom_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_o <= '0;
        end else if (zeroize_i) begin
            instr_o <= '0;
        end else begin
            instr_o <= rom_word;
        end
    end

endmodule

/* source/dsa_ctrl_fsm.sv */
// controller FSM stepping through microcode with stall, dispatch and done pulse
module dsa_ctrl_fsm (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize_i,
    input  logic                                cmd_valid_i,
    input  ecc_dsa_pkg::cmd_e                   cmd_i,
    input  ecc_dsa_pkg::instr_u                 instr_i,
    input  logic                                error_i,
    output logic                                ready_o,
    output logic [ecc_dsa_pkg::PROG_ADDR_W-1:0] addr_o,
    output logic                                keygen_o,
    output logic                                sign_o,
    output logic                                done_o,
    output logic                                valid_o,
    ecc_arith_if.ctrl                           arith
);
    import ecc_dsa_pkg::*;

    logic [PROG_ADDR_W-1:0] pc_q;
    logic [1:0]             cyc_q;
    logic                   run_q;
    logic                   keygen_q;
    logic                   sign_q;
    logic                   done_q;
    logic                   valid_q;
    logic                   accept;
    logic                   is_arith;

    assign ready_o  = !run_q && !error_i;
    assign accept   = cmd_valid_i && ready_o && (cmd_i == CMD_KEYGEN || cmd_i == CMD_SIGN);
    assign is_arith = instr_i.arith.kind == UOP_ARITH;

    // ROM output is valid from cycle 1, so the request goes out then
    assign arith.start      = run_q && (cyc_q == 2'd1) && is_arith && !arith.busy && !error_i;
    assign arith.op         = instr_i.arith.op;
    assign arith.dst_addr   = instr_i.arith.dst_a;
    assign arith.src_a_addr = is_arith ? instr_i.arith.dst_a : instr_i.xfer.mem_addr;
    assign arith.src_b_addr = instr_i.arith.src_b;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_q <= PROG_RESET;
            cyc_q <= '0;
            run_q <= 1'b1;
            {keygen_q, sign_q, done_q, valid_q} <= '0;
        end else if (zeroize_i) begin
            pc_q <= PROG_RESET;
            cyc_q <= '0;
            run_q <= 1'b1;
            {keygen_q, sign_q, done_q, valid_q} <= '0;
        end else if (error_i) begin
            // abort and park until zeroize
            cyc_q <= '0;
            run_q <= 1'b0;
            {keygen_q, sign_q, done_q} <= '0;
        end else begin
            done_q <= 1'b0;
            if (!run_q) begin
                if (accept) begin
                    pc_q <= (cmd_i == CMD_SIGN) ? PROG_SIGN : PROG_KEYGEN;
                    cyc_q <= '0;
                    run_q <= 1'b1;
                    keygen_q <= cmd_i == CMD_KEYGEN;
                    sign_q <= cmd_i == CMD_SIGN;
                    valid_q <= 1'b0;
                end
            end else if (arith.busy) begin
                // stalled, pc and cycle count hold
            end else if (cyc_q != 2'd3) begin
                cyc_q <= cyc_q + 2'd1;
            end else begin
                cyc_q <= '0;
                if (instr_i.xfer.kind == UOP_END) begin
                    run_q <= 1'b0;
                    keygen_q <= 1'b0;
                    sign_q <= 1'b0;
                    // the reset program finishes silently
                    if (keygen_q || sign_q) begin
                        done_q <= 1'b1;
                        valid_q <= 1'b1;
                    end
                end else begin
                    pc_q <= pc_q + 5'd1;
                end
            end
        end
    end

    assign addr_o   = pc_q;
    assign keygen_o = keygen_q;
    assign sign_o   = sign_q;
    assign done_o   = done_q;
    assign valid_o  = valid_q;

endmodule

/* source/dsa_reg_bank.sv */
// register bank with operand capture, message reduction and memory transfers
module dsa_reg_bank (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  capture_i,
    input  ecc_dsa_pkg::operand_t privkey_i,
    input  ecc_dsa_pkg::operand_t nonce_i,
    input  ecc_dsa_pkg::operand_t msg_i,
    input  ecc_dsa_pkg::instr_u   instr_i,
    output ecc_dsa_pkg::operand_t privkey_o,
    output ecc_dsa_pkg::operand_t nonce_o,
    output logic                  r_wr_o,
    output logic                  s_wr_o,
    output ecc_dsa_pkg::operand_t rd_word_o,
    output ecc_dsa_pkg::operand_t pubkey_o,
    output ecc_dsa_pkg::operand_t r_o,
    output ecc_dsa_pkg::operand_t s_o,
    ecc_arith_if.bank             mem
);
    import ecc_dsa_pkg::*;

    operand_t privkey_q;
    operand_t nonce_q;
    operand_t msg_q;
    operand_t msg_red_q;
    operand_t pubkey_q;
    operand_t r_q;
    operand_t s_q;
    instr_u   rd_instr_q;
    logic     pubkey_we;

    // ----------------------------------------
    // input capture and message reduction
    // ----------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            {privkey_q, nonce_q, msg_q, msg_red_q} <= '0;
        end else if (zeroize_i) begin
            {privkey_q, nonce_q, msg_q, msg_red_q} <= '0;
        end else begin
            if (capture_i) begin
                privkey_q <= privkey_i;
                nonce_q <= nonce_i;
                msg_q <= msg_i;
            end
            // one subtract is enough since 2q exceeds the word range
            msg_red_q <= (msg_q >= GROUP_ORDER) ? msg_q - GROUP_ORDER : msg_q;
        end
    end

    // constant or operand into data memory on WR_CORE
    assign mem.we    = instr_i.xfer.kind == UOP_WR_CORE;
    assign mem.waddr = instr_i.xfer.mem_addr;

    always_comb begin
        case (instr_i.xfer.reg_id)
            ID_CONST_GEN : mem.wdata = GEN_X;
            ID_PRIVKEY   : mem.wdata = privkey_q;
            ID_NONCE     : mem.wdata = nonce_q;
            ID_MSG       : mem.wdata = msg_red_q;
            default      : mem.wdata = '0;
        endcase
    end

    // ----------------------------------------
    // read-back, paired with the instruction that set the address
    // ----------------------------------------
    always_comb begin
        pubkey_we = 1'b0;
        r_wr_o = 1'b0;
        s_wr_o = 1'b0;
        if (rd_instr_q.xfer.kind == UOP_RD_CORE) begin
            case (rd_instr_q.xfer.reg_id)
                ID_PUBKEY : pubkey_we = 1'b1;
                ID_R      : r_wr_o = 1'b1;
                ID_S      : s_wr_o = 1'b1;
                default   : pubkey_we = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_instr_q <= '0;
            {pubkey_q, r_q, s_q} <= '0;
        end else if (zeroize_i) begin
            rd_instr_q <= '0;
            {pubkey_q, r_q, s_q} <= '0;
        end else begin
            rd_instr_q <= instr_i;
            if (pubkey_we) pubkey_q <= mem.rdata;
            if (r_wr_o) r_q <= mem.rdata;
            if (s_wr_o) s_q <= mem.rdata;
        end
    end

    assign privkey_o = privkey_q;
    assign nonce_o   = nonce_q;
    assign rd_word_o = mem.rdata;
    assign pubkey_o  = pubkey_q;
    assign r_o       = r_q;
    assign s_o       = s_q;

endmodule

/* source/dsa_error_check.sv */
// range checks on scalars and signature words with a sticky error flag
module dsa_error_check (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  keygen_i,
    input  logic                  sign_i,
    input  ecc_dsa_pkg::operand_t privkey_i,
    input  ecc_dsa_pkg::operand_t nonce_i,
    input  logic                  r_wr_i,
    input  logic                  s_wr_i,
    input  ecc_dsa_pkg::operand_t rd_word_i,
    output logic                  error_o
);
    import ecc_dsa_pkg::*;

    logic privkey_bad;
    logic nonce_bad;
    logic r_bad;
    logic s_bad;
    logic error_q;

    // privkey must lie in [1, q-1] for both commands
    assign privkey_bad = (keygen_i || sign_i) && (privkey_i == '0 || privkey_i >= GROUP_ORDER);
    assign nonce_bad   = sign_i && nonce_i == '0;
    assign r_bad       = sign_i && r_wr_i && rd_word_i == '0;
    assign s_bad       = sign_i && s_wr_i && rd_word_i == '0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            error_q <= 1'b0;
        end else if (zeroize_i) begin
            error_q <= 1'b0;
        end else if (privkey_bad || nonce_bad || r_bad || s_bad) begin
            error_q <= 1'b1;
        end
    end

    assign error_o = error_q;

endmodule

/* source/ecc_arith_unit.sv */
// arithmetic unit with data memory, bit-serial modular multiplier and modular adder
module ecc_arith_unit #(
    parameter int MEM_DEPTH = 16
) (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      zeroize_i,
    ecc_arith_if.unit arith
);
    import ecc_dsa_pkg::*;

    localparam int CNT_W = $clog2(REG_SIZE + 1);

    operand_t              mem [MEM_DEPTH];
    operand_t              acc_q;
    operand_t              a_q;
    operand_t              b_q;
    operand_t              mod_q;
    logic [OPR_ADDR_W-1:0] dst_q;
    logic [CNT_W-1:0]      cnt_q;
    logic                  busy_q;
    logic                  accept;
    logic                  res_we;
    operand_t              opnd_a;
    operand_t              opnd_b;
    operand_t              step_dbl;
    operand_t              step_next;

    // x + y mod m, valid for x and y below m
    function automatic operand_t add_mod(operand_t x, operand_t y, operand_t m);
        logic [REG_SIZE:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        if (sum >= {1'b0, m}) sum = sum - {1'b0, m};
        return sum[REG_SIZE-1:0];
    endfunction

    assign accept = arith.start && !busy_q;
    assign res_we = busy_q && cnt_q == '0;
    assign opnd_a = mem[arith.src_a_addr];
    assign opnd_b = mem[arith.src_b_addr];

    // one multiplier step: double, then add b when the scanned bit is set
    assign step_dbl  = add_mod(acc_q, acc_q, mod_q);
    assign step_next = a_q[REG_SIZE-1] ? add_mod(step_dbl, b_q, mod_q) : step_dbl;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
            cnt_q <= '0;
        end else if (zeroize_i) begin
            busy_q <= 1'b0;
            cnt_q <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q <= (arith.op == OP_ADD_Q) ? '0 : CNT_W'(REG_SIZE);
        end else if (res_we) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= opnd_a;
            b_q <= opnd_b;
            mod_q <= (arith.op == OP_MUL_P) ? PRIME : GROUP_ORDER;
            dst_q <= arith.dst_addr;
            acc_q <= (arith.op == OP_ADD_Q) ? add_mod(opnd_a, opnd_b, GROUP_ORDER) : '0;
        end else if (busy_q && !res_we) begin
            acc_q <= step_next;
            a_q <= a_q << 1;
        end
    end

    // single write port, the result write wins over bank writes
    always_ff @(posedge clk) begin
        if (res_we) begin
            mem[dst_q] <= acc_q;
        end else if (arith.we) begin
            mem[arith.waddr] <= arith.wdata;
        end
        arith.rdata <= mem[arith.src_a_addr];
    end

    assign arith.busy = busy_q;

endmodule

/* source/ecdsa_engine_top.sv */
// signing engine top level connecting sequencer, controller, bank, checks and arithmetic
module ecdsa_engine_top (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  cmd_valid_i,
    input  ecc_dsa_pkg::cmd_e     cmd_i,
    input  ecc_dsa_pkg::operand_t privkey_i,
    input  ecc_dsa_pkg::operand_t nonce_i,
    input  ecc_dsa_pkg::operand_t msg_i,
    input  logic                  zeroize_i,
    output logic                  ready_o,
    output ecc_dsa_pkg::operand_t pubkey_o,
    output ecc_dsa_pkg::operand_t r_o,
    output ecc_dsa_pkg::operand_t s_o,
    output logic                  valid_o,
    output logic                  done_o,
    output logic                  error_o
);
    import ecc_dsa_pkg::*;

    instr_u                 instr;
    logic [PROG_ADDR_W-1:0] prog_addr;
    logic                   keygen;
    logic                   sign;
    operand_t               privkey_q;
    operand_t               nonce_q;
    operand_t               rd_word;
    logic                   r_wr;
    logic                   s_wr;

    ecc_arith_if arith_bus ();

    dsa_sequencer_rom dsa_sequencer_rom_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .addr_i(prog_addr), .instr_o(instr)
    );

    dsa_ctrl_fsm dsa_ctrl_fsm_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i), .instr_i(instr), .error_i(error_o),
        .ready_o(ready_o), .addr_o(prog_addr), .keygen_o(keygen), .sign_o(sign),
        .done_o(done_o), .valid_o(valid_o), .arith(arith_bus.ctrl)
    );

    // operands follow the inputs while ready and freeze at accept
    dsa_reg_bank dsa_reg_bank_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .capture_i(ready_o),
        .privkey_i(privkey_i), .nonce_i(nonce_i), .msg_i(msg_i), .instr_i(instr),
        .privkey_o(privkey_q), .nonce_o(nonce_q), .r_wr_o(r_wr), .s_wr_o(s_wr),
        .rd_word_o(rd_word), .pubkey_o(pubkey_o), .r_o(r_o), .s_o(s_o),
        .mem(arith_bus.bank)
    );

    dsa_error_check dsa_error_check_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .keygen_i(keygen), .sign_i(sign), .privkey_i(privkey_q), .nonce_i(nonce_q),
        .r_wr_i(r_wr), .s_wr_i(s_wr), .rd_word_i(rd_word), .error_o(error_o)
    );

    ecc_arith_unit #(
        .MEM_DEPTH(16)
    ) ecc_arith_unit_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .arith(arith_bus.unit)
    );

endmodule

/* tests/ecdsa_engine_sva.sv */
// assertions on the signing engine done pulse, error hold and reset outputs
module ecdsa_engine_sva (
    input logic clk,
    input logic reset_n,
    input logic zeroize_i,
    input logic ready_i,
    input logic valid_i,
    input logic done_i,
    input logic error_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench to end the run
    int unsigned fail_count = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else begin
            fail_count++;
            $error("done_o stayed high for more than one cycle");
        end

    done_without_error: assert property (@(posedge clk) disable iff (!reset_n)
        !(done_i && error_i))
        else begin
            fail_count++;
            $error("done_o fired while error_o was high");
        end

    // error and not-ready hold until zeroize
    error_held_until_zeroize: assert property (@(posedge clk) disable iff (!reset_n)
        error_i && !zeroize_i |=> error_i && !ready_i)
        else begin
            fail_count++;
            $error("error_o dropped or ready_o rose before zeroize");
        end

    // first sampled cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(reset_n) |-> !valid_i && !done_i && !error_i)
        else begin
            fail_count++;
            $error("outputs were not quiet after reset");
        end

endmodule

bind ecdsa_engine_top ecdsa_engine_sva ecdsa_engine_sva_inst (
    .clk(clk),
    .reset_n(reset_n),
    .zeroize_i(zeroize_i),
    .ready_i(ready_o),
    .valid_i(valid_o),
    .done_i(done_o),
    .error_i(error_o)
);

/* tests/ecdsa_engine_tb.sv */
// testbench for the signing engine with random keygen and sign commands and error cases
module ecdsa_engine_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ecc_dsa_pkg::*;

    localparam int N_KEYGEN      = 6;
    localparam int N_SIGN        = 6;
    // random commands, error cases, recovery keygens and reset programs
    localparam int NUM_CMDS      = N_KEYGEN + N_SIGN + 10;
    localparam int TIMEOUT_LIMIT = NUM_CMDS * (4 * 40 + 3 * 33) + 500;

    typedef struct packed {
        operand_t pubkey;
        operand_t r;
        operand_t s;
    } result_t;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        cmd_valid_i;
    cmd_e        cmd_i;
    operand_t    privkey_i;
    operand_t    nonce_i;
    operand_t    msg_i;
    logic        zeroize_i;
    logic        ready_o;
    operand_t    pubkey_o;
    operand_t    r_o;
    operand_t    s_o;
    logic        valid_o;
    logic        done_o;
    logic        error_o;

    logic [31:0] lcg_state = 32'd89;
    int unsigned done_count = 0;
    int unsigned cycle_count = 0;
    cmd_e        exp_cmd_q[$];
    result_t     exp_res_q[$];

    ecdsa_engine_top ecdsa_engine_top_inst (
        .clk(clk), .reset_n(reset_n), .cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i),
        .privkey_i(privkey_i), .nonce_i(nonce_i), .msg_i(msg_i), .zeroize_i(zeroize_i),
        .ready_o(ready_o), .pubkey_o(pubkey_o), .r_o(r_o), .s_o(s_o),
        .valid_o(valid_o), .done_o(done_o), .error_o(error_o)
    );

    always #20 clk = ~clk;

    // ----------------------------------------
    // random numbers and reference model
    // ----------------------------------------
    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(output operand_t v);
        lcg_state = lcg_step(lcg_state);
        v = lcg_state;
    endtask

    // private key in [1, q-1]
    task automatic draw_privkey(output operand_t v);
        draw(v);
        while (v == '0 || v >= GROUP_ORDER) draw(v);
    endtask

    function automatic result_t ref_result(cmd_e cmd, operand_t d, operand_t k, operand_t h);
        result_t     res;
        logic [63:0] wide;
        res = '0;
        if (cmd == CMD_KEYGEN) begin
            wide = 64'(d) * 64'(GEN_X);
            res.pubkey = operand_t'(wide % 64'(PRIME));
        end else begin
            wide = 64'(k) * 64'(GEN_X);
            res.r = operand_t'(wide % 64'(PRIME));
            wide = (64'(d) * 64'(res.r)) % 64'(GROUP_ORDER) + 64'(h) % 64'(GROUP_ORDER);
            res.s = operand_t'(wide % 64'(GROUP_ORDER));
        end
        return res;
    endfunction

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic stop_with_failure(string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(string name, operand_t exp, operand_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            stop_with_failure("operand mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            stop_with_failure("status bit mismatch");
        end
    endtask

    // results are stable around the falling edge
    always @(negedge clk) begin : compare_results
        cmd_e    exp_cmd;
        result_t exp_res;
        if (reset_n === 1'b1 && done_o === 1'b1) begin
            if (exp_cmd_q.size() == 0) begin
                stop_with_failure("done_o pulsed with no command outstanding");
            end else begin
                exp_cmd = exp_cmd_q.pop_front();
                exp_res = exp_res_q.pop_front();
                check_bit("valid at done", 1'b1, valid_o);
                if (exp_cmd == CMD_KEYGEN) begin
                    check_word("keygen pubkey", exp_res.pubkey, pubkey_o);
                end else begin
                    check_word("sign r", exp_res.r, r_o);
                    check_word("sign s", exp_res.s, s_o);
                end
                done_count++;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_count++;
        if (cycle_count >= TIMEOUT_LIMIT) begin
            stop_with_failure("timeout, the run went past its cycle limit");
        end else if (ecdsa_engine_top_inst.ecdsa_engine_sva_inst.fail_count != 0) begin
            stop_with_failure("a bound assertion failed");
        end
    end

    // ----------------------------------------
    // stimulus tasks
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_ready();
        while (ready_o !== 1'b1) next_cycle();
    endtask

    task automatic drive_command(cmd_e cmd, operand_t d, operand_t k, operand_t h);
        check_bit("ready before accept", 1'b1, ready_o);
        cmd_valid_i = 1'b1;
        cmd_i = cmd;
        privkey_i = d;
        nonce_i = k;
        msg_i = h;
        next_cycle();
        cmd_valid_i = 1'b0;
        cmd_i = CMD_NOP;
    endtask

    task automatic run_good(cmd_e cmd, operand_t d, operand_t k, operand_t h);
        int unsigned dones;
        dones = done_count;
        wait_ready();
        exp_cmd_q.push_back(cmd);
        exp_res_q.push_back(ref_result(cmd, d, k, h));
        drive_command(cmd, d, k, h);
        check_bit("valid cleared at accept", 1'b0, valid_o);
        while (done_count == dones) next_cycle();
        check_bit("valid held after done", 1'b1, valid_o);
    endtask

    task automatic run_rejected(string name, cmd_e cmd, operand_t d, operand_t k,
                                operand_t h);
        int unsigned dones;
        int          waited;
        dones = done_count;
        waited = 0;
        wait_ready();
        drive_command(cmd, d, k, h);
        while (error_o !== 1'b1 && waited < 4) begin
            next_cycle();
            waited++;
        end
        check_bit(name, 1'b1, error_o);
        repeat (10) next_cycle();
        check_bit("ready low while error held", 1'b0, ready_o);
        check_bit("error still held", 1'b1, error_o);
        if (done_count != dones) stop_with_failure("done_o pulsed for a rejected command");
    endtask

    task automatic clear_error();
        zeroize_i = 1'b1;
        next_cycle();
        zeroize_i = 1'b0;
        check_bit("error cleared by zeroize", 1'b0, error_o);
        check_bit("valid cleared by zeroize", 1'b0, valid_o);
        wait_ready();
    endtask

    initial begin : stimulus
        operand_t    d;
        operand_t    k;
        operand_t    h;
        int unsigned dones;
        reset_n = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i = CMD_NOP;
        privkey_i = '0;
        nonce_i = '0;
        msg_i = '0;
        zeroize_i = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b1;
        wait_ready();

        for (int i = 0; i < N_KEYGEN; i++) begin
            draw_privkey(d);
            run_good(CMD_KEYGEN, d, '0, '0);
        end

        // some messages at or just above the group order
        for (int i = 0; i < N_SIGN; i++) begin
            draw_privkey(d);
            draw(k);
            if (k == '0) k = 32'd1;
            draw(h);
            if (i == 2) begin
                h = GROUP_ORDER;
            end else if (i % 3 == 1) begin
                h = GROUP_ORDER + operand_t'(h[3:0]);
            end
            run_good(CMD_SIGN, d, k, h);
        end

        // ----------------------------------------
        // range errors and recovery by zeroize
        // ----------------------------------------
        run_rejected("privkey zero", CMD_KEYGEN, '0, '0, '0);
        clear_error();
        draw(k);
        run_rejected("privkey at order", CMD_SIGN, GROUP_ORDER, k | 32'd1, k);
        clear_error();
        draw_privkey(d);
        run_good(CMD_KEYGEN, d, '0, '0);
        // zeroize while a result is held drops valid
        clear_error();
        draw_privkey(d);
        draw(h);
        run_rejected("nonce zero", CMD_SIGN, d, '0, h);
        clear_error();

        // a held command while busy must not start a second run
        draw_privkey(d);
        dones = done_count;
        wait_ready();
        exp_cmd_q.push_back(CMD_KEYGEN);
        exp_res_q.push_back(ref_result(CMD_KEYGEN, d, '0, '0));
        drive_command(CMD_KEYGEN, d, '0, '0);
        cmd_valid_i = 1'b1;
        cmd_i = CMD_SIGN;
        privkey_i = ~d;
        repeat (30) next_cycle();
        cmd_valid_i = 1'b0;
        cmd_i = CMD_NOP;
        while (done_count == dones) next_cycle();
        repeat (20) next_cycle();
        if (done_count != dones + 1) stop_with_failure("a command was accepted while busy");
        check_bit("ready after single run", 1'b1, ready_o);

        if (ecdsa_engine_top_inst.ecdsa_engine_sva_inst.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_with_failure("a bound assertion failed");
        end
    end

endmodule

/* ecdsa_engine.f */
source/ecc_dsa_pkg.sv
source/ecc_arith_if.sv
source/dsa_sequencer_rom.sv
source/dsa_ctrl_fsm.sv
source/dsa_reg_bank.sv
source/dsa_error_check.sv
source/ecc_arith_unit.sv
source/ecdsa_engine_top.sv
tests/ecdsa_engine_sva.sv
tests/ecdsa_engine_tb.sv
